/* design/pu_mem_pkg.sv */
// NUM_PU must be a power of two equal to 2**PU_ID_W; addresses are word addresses, not byte addresses.
package pu_mem_pkg;

	localparam int NUM_PU = 4;
	localparam int PU_ID_W = 2;

	localparam int DATA_W = 32;
	localparam int TID_W = 2; // Thread id bits at the top of the RAM address.
	localparam int WORD_W = 6;
	localparam int RAM_AW = TID_W + WORD_W;

	localparam int ADDR_W = 16;
	localparam int REGION_HI = 15;
	localparam int REGION_LO = 12;
	localparam logic [REGION_HI-REGION_LO:0] TOPIC_REGION = 4'd3;

	// RISC-V AMO funct5 codes.
	localparam int FUNCT_W = 5;
	localparam logic [FUNCT_W-1:0] AMO_ADD = 5'b00000;
	localparam logic [FUNCT_W-1:0] AMO_SWAP = 5'b00001; // Only code matched on all five bits.
	localparam logic [FUNCT_W-1:0] AMO_XOR = 5'b00100;
	localparam logic [FUNCT_W-1:0] AMO_OR = 5'b01000;
	localparam logic [FUNCT_W-1:0] AMO_AND = 5'b01100;
	localparam logic [FUNCT_W-1:0] AMO_MIN = 5'b10000;
	localparam logic [FUNCT_W-1:0] AMO_MAX = 5'b10100;
	localparam logic [FUNCT_W-1:0] AMO_MINU = 5'b11000;
	localparam logic [FUNCT_W-1:0] AMO_MAXU = 5'b11100;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [PU_ID_W-1:0] pu_id_t;
	typedef logic [NUM_PU-1:0] pu_mask_t;
	typedef logic [TID_W-1:0] tid_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [RAM_AW-1:0] ram_addr_t;
	typedef logic [FUNCT_W-1:0] funct_t;

endpackage

/* design/req_slot.sv */
// Holds one command only; the PU must not issue a new request until the previous one has been acked.
`timescale 1ns/1ps

module req_slot (
	input logic clk,
	input logic reset,
	input logic load,
	input logic clear,
	input logic cmd_wr,
	input logic cmd_atomic,
	input pu_mem_pkg::funct_t cmd_funct,
	input pu_mem_pkg::tid_t cmd_tid,
	input logic [pu_mem_pkg::WORD_W-1:0] cmd_word,
	input pu_mem_pkg::data_t cmd_wdata,
	output logic full,
	output logic q_wr,
	output logic q_atomic,
	output pu_mem_pkg::funct_t q_funct,
	output pu_mem_pkg::tid_t q_tid,
	output logic [pu_mem_pkg::WORD_W-1:0] q_word,
	output pu_mem_pkg::data_t q_wdata
);

	always_ff @(posedge clk) begin
		if (reset)
			full <= 1'b0;
		else if (load)
			full <= 1'b1;
		else if (clear)
			full <= 1'b0;
	end

	// The fields stay valid after the grant until the atomic write-back has used them.
	always_ff @(posedge clk) begin
		if (load) begin
			q_wr <= cmd_wr;
			q_atomic <= cmd_atomic;
			q_funct <= cmd_funct;
			q_tid <= cmd_tid;
			q_word <= cmd_word;
			q_wdata <= cmd_wdata;
		end
	end

	a_no_overrun: assert property (@(posedge clk) disable iff (reset)
		load |-> (!full || clear));

endmodule

/* design/rr_arbiter.sv */
// Grant is combinational from req and en; the priority pointer moves past the winner on each grant.
`timescale 1ns/1ps

module rr_arbiter (
	input logic clk,
	input logic reset,
	input logic en,
	input pu_mem_pkg::pu_mask_t req,
	output pu_mem_pkg::pu_mask_t ack,
	output pu_mem_pkg::pu_id_t sel,
	output logic gnt
);

	import pu_mem_pkg::*;

	pu_id_t ptr; // PU with the highest priority this cycle.

	always_comb begin
		pu_id_t idx;
		gnt = 1'b0;
		sel = ptr;
		for (int k = 0; k < NUM_PU; k++) begin
			idx = pu_id_t'(ptr + k); // Wraps because NUM_PU is a power of two.
			if (en && !gnt && req[idx]) begin
				gnt = 1'b1;
				sel = idx;
			end
		end
		ack = '0;
		ack[sel] = gnt;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ptr <= '0;
		else if (gnt)
			ptr <= pu_id_t'(sel + 1'b1);
	end

	a_ack_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(ack));

	a_gnt_matches_ack: assert property (@(posedge clk) disable iff (reset)
		gnt == (|ack));

	// A granted requester loses priority to every other waiting one next cycle.
	a_no_repeat_winner: assert property (@(posedge clk) disable iff (reset)
		(gnt && ((req & ~ack) != '0)) |=> !(gnt && ack == $past(ack) && $past(req) == req));

endmodule

/* design/amo_alu.sv */
// Purely combinational; codes other than swap are decoded on funct bits 4:2 only.
`timescale 1ns/1ps

module amo_alu (
	input pu_mem_pkg::funct_t funct,
	input pu_mem_pkg::data_t operand,
	input pu_mem_pkg::data_t old_word,
	output pu_mem_pkg::data_t new_word
);

	import pu_mem_pkg::*;

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed = $signed(operand) < $signed(old_word);
	assign lt_unsigned = operand < old_word;

	always_comb begin
		if (funct == AMO_SWAP) begin
			new_word = operand;
		end else begin
			case (funct[FUNCT_W-1:2])
				AMO_ADD[FUNCT_W-1:2]: new_word = operand + old_word;
				AMO_XOR[FUNCT_W-1:2]: new_word = operand ^ old_word;
				AMO_OR[FUNCT_W-1:2]: new_word = operand | old_word;
				AMO_AND[FUNCT_W-1:2]: new_word = operand & old_word;
				AMO_MIN[FUNCT_W-1:2]: new_word = lt_signed ? operand : old_word;
				AMO_MAX[FUNCT_W-1:2]: new_word = lt_signed ? old_word : operand;
				AMO_MINU[FUNCT_W-1:2]: new_word = lt_unsigned ? operand : old_word;
				AMO_MAXU[FUNCT_W-1:2]: new_word = lt_unsigned ? old_word : operand;
			endcase
		end
	end

endmodule

/* design/ram_1r1w.sv */
// Contents are undefined after power-up; a read of the word being written returns the new word.
`timescale 1ns/1ps

module ram_1r1w (
	input logic clk,
	input logic wr,
	input pu_mem_pkg::ram_addr_t raddr,
	input pu_mem_pkg::ram_addr_t waddr,
	input pu_mem_pkg::data_t din,
	output pu_mem_pkg::data_t dout
);

	import pu_mem_pkg::*;

	data_t mem [2**RAM_AW];

	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= din;
	end

	// Write-first so a read right after an atomic write-back sees the updated word.
	always_ff @(posedge clk) begin
		if (wr && waddr == raddr)
			dout <= din;
		else
			dout <= mem[raddr];
	end

endmodule

/* design/pu_topic_mem.sv */
// One request per PU at a time; requests outside the topic region are dropped without an ack.
`timescale 1ns/1ps

module pu_topic_mem (
	input logic clk,
	input logic reset,
	input pu_mem_pkg::pu_mask_t req,
	input pu_mem_pkg::pu_mask_t wr,
	input pu_mem_pkg::pu_mask_t atomic,
	input pu_mem_pkg::funct_t [pu_mem_pkg::NUM_PU-1:0] funct,
	input pu_mem_pkg::tid_t [pu_mem_pkg::NUM_PU-1:0] tid,
	input pu_mem_pkg::addr_t [pu_mem_pkg::NUM_PU-1:0] addr,
	input pu_mem_pkg::data_t [pu_mem_pkg::NUM_PU-1:0] wdata,
	output pu_mem_pkg::pu_mask_t ack,
	output pu_mem_pkg::data_t [pu_mem_pkg::NUM_PU-1:0] ack_data
);

	import pu_mem_pkg::*;

	pu_mask_t slot_load;
	pu_mask_t slot_clear;
	pu_mask_t slot_full;
	pu_mask_t q_wr;
	pu_mask_t q_atomic;
	funct_t [NUM_PU-1:0] q_funct;
	tid_t [NUM_PU-1:0] q_tid;
	logic [NUM_PU-1:0][WORD_W-1:0] q_word;
	data_t [NUM_PU-1:0] q_wdata;
	ram_addr_t [NUM_PU-1:0] slot_addr;

	pu_mask_t hit_now;
	pu_mask_t hit_d1;
	pu_mask_t rd_req;
	pu_mask_t wr_req;
	pu_mask_t rd_ack;
	pu_mask_t wr_ack;
	pu_id_t rd_sel;
	pu_id_t wr_sel;
	logic rd_gnt;
	logic wr_gnt;

	logic atomic_rd;
	logic atomic_d1;
	logic atomic_d2;
	pu_id_t rd_sel_d1;
	pu_id_t rd_sel_d2;
	ram_addr_t ram_raddr;
	ram_addr_t raddr_d1;
	ram_addr_t raddr_d2;

	logic ram_wr;
	ram_addr_t ram_waddr;
	data_t ram_wdata;
	data_t ram_dout;
	data_t old_word;
	data_t amo_word;

	pu_mask_t ack_d1;
	pu_mask_t rd_ack_d1;

	genvar gi;
	generate
		for (gi = 0; gi < NUM_PU; gi++) begin : g_slot
			assign slot_load[gi] = req[gi] && addr[gi][REGION_HI:REGION_LO] == TOPIC_REGION;
			assign slot_addr[gi] = {q_tid[gi], q_word[gi]};

			req_slot i_req_slot (
				.clk(clk),
				.reset(reset),
				.load(slot_load[gi]),
				.clear(slot_clear[gi]),
				.cmd_wr(wr[gi]),
				.cmd_atomic(atomic[gi]),
				.cmd_funct(funct[gi]),
				.cmd_tid(tid[gi]),
				.cmd_word(addr[gi][WORD_W-1:0]),
				.cmd_wdata(wdata[gi]),
				.full(slot_full[gi]),
				.q_wr(q_wr[gi]),
				.q_atomic(q_atomic[gi]),
				.q_funct(q_funct[gi]),
				.q_tid(q_tid[gi]),
				.q_word(q_word[gi]),
				.q_wdata(q_wdata[gi])
			);
		end
	endgenerate

	assign slot_clear = rd_ack | wr_ack;
	assign ram_raddr = slot_addr[rd_sel];
	assign atomic_rd = rd_gnt && q_atomic[rd_sel];

	// Words with an atomic between its read and its write-back are held back.
	always_comb begin
		for (int i = 0; i < NUM_PU; i++) begin
			hit_now[i] = atomic_rd && slot_addr[i] == ram_raddr;
			hit_d1[i] = atomic_d1 && slot_addr[i] == raddr_d1;
			rd_req[i] = slot_full[i] && (!q_wr[i] || q_atomic[i]) && !hit_d1[i];
			wr_req[i] = slot_full[i] && q_wr[i] && !q_atomic[i] && !hit_now[i] && !hit_d1[i];
		end
	end

	rr_arbiter i_rd_arbiter (
		.clk(clk),
		.reset(reset),
		.en(1'b1),
		.req(rd_req),
		.ack(rd_ack),
		.sel(rd_sel),
		.gnt(rd_gnt)
	);

	rr_arbiter i_wr_arbiter (
		.clk(clk),
		.reset(reset),
		.en(!atomic_d2), // The write-back owns the write port this cycle.
		.req(wr_req),
		.ack(wr_ack),
		.sel(wr_sel),
		.gnt(wr_gnt)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			atomic_d1 <= 1'b0;
			atomic_d2 <= 1'b0;
		end else begin
			atomic_d1 <= atomic_rd;
			atomic_d2 <= atomic_d1;
		end
	end

	always_ff @(posedge clk) begin
		rd_sel_d1 <= rd_sel;
		rd_sel_d2 <= rd_sel_d1;
		raddr_d1 <= ram_raddr;
		raddr_d2 <= raddr_d1;
		old_word <= ram_dout;
	end

	// Slot fields are still intact here because the PU has not seen its ack yet.
	amo_alu i_amo_alu (
		.funct(q_funct[rd_sel_d2]),
		.operand(q_wdata[rd_sel_d2]),
		.old_word(old_word),
		.new_word(amo_word)
	);

	assign ram_wr = atomic_d2 || wr_gnt;
	assign ram_waddr = atomic_d2 ? raddr_d2 : slot_addr[wr_sel];
	assign ram_wdata = atomic_d2 ? amo_word : q_wdata[wr_sel];

	ram_1r1w i_ram (
		.clk(clk),
		.wr(ram_wr),
		.raddr(ram_raddr),
		.waddr(ram_waddr),
		.din(ram_wdata),
		.dout(ram_dout)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_d1 <= '0;
			rd_ack_d1 <= '0;
			ack <= '0;
		end else begin
			ack_d1 <= slot_clear;
			rd_ack_d1 <= rd_ack;
			ack <= ack_d1;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_PU; i++)
			ack_data[i] <= rd_ack_d1[i] ? ram_dout : '0; // Plain writes ack with zero.
	end

	a_wb_no_write_grant: assert property (@(posedge clk) disable iff (reset)
		!(atomic_d2 && wr_gnt));

endmodule

/* verification/pu_topic_mem_tb.sv */
// Must run from the project root since the data file path is relative; one open request per PU.
`timescale 1ns/1ps

module pu_topic_mem_tb;

	import pu_mem_pkg::*;

	localparam int ACK_TIMEOUT = 100;
	localparam int DROP_WINDOW = 20;

	logic clk;
	logic reset;
	pu_mask_t req;
	pu_mask_t wr;
	pu_mask_t atomic;
	funct_t [NUM_PU-1:0] funct;
	tid_t [NUM_PU-1:0] tid;
	addr_t [NUM_PU-1:0] addr;
	data_t [NUM_PU-1:0] wdata;
	pu_mask_t ack;
	data_t [NUM_PU-1:0] ack_data;

	// Next command of each PU, copied to the ports on a falling edge.
	pu_mask_t st_wr;
	pu_mask_t st_atomic;
	funct_t [NUM_PU-1:0] st_funct;
	tid_t [NUM_PU-1:0] st_tid;
	addr_t [NUM_PU-1:0] st_addr;
	data_t [NUM_PU-1:0] st_wdata;

	data_t exp_data [NUM_PU];
	data_t got_data [NUM_PU];
	int fd;

	pu_topic_mem i_pu_topic_mem (
		.clk(clk),
		.reset(reset),
		.req(req),
		.wr(wr),
		.atomic(atomic),
		.funct(funct),
		.tid(tid),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.ack_data(ack_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic end_with_failure();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic compare(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic clear_staging();
		st_wr = '0;
		st_atomic = '0;
		st_funct = '0;
		st_tid = '0;
		st_addr = '0;
		st_wdata = '0;
	endtask

	// Kind 0 is a read, 1 a plain write and 2 an atomic.
	task automatic stage(input int p, input logic [31:0] kind, input logic [31:0] fn,
			input logic [31:0] t, input logic [31:0] a, input logic [31:0] wd);
		st_wr[p] = kind == 32'd1;
		st_atomic[p] = kind == 32'd2;
		st_funct[p] = fn[FUNCT_W-1:0];
		st_tid[p] = t[TID_W-1:0];
		st_addr[p] = a[ADDR_W-1:0];
		st_wdata[p] = wd;
	endtask

	task automatic load_fields(input pu_mask_t mask);
		logic [31:0] kind;
		logic [31:0] fn;
		logic [31:0] t;
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] ex;
		int n;
		clear_staging();
		for (int p = 0; p < NUM_PU; p++) begin
			if (mask[p]) begin
				n = $fscanf(fd, "%h %h %h %h %h %h", kind, fn, t, a, wd, ex);
				if (n != 6) begin
					$display("A request line in the data file is missing fields for PU %0d", p);
					end_with_failure();
				end else begin
					stage(p, kind, fn, t, a, wd);
					exp_data[p] = ex;
				end
			end
		end
	endtask

	task automatic drive_request(input pu_mask_t mask);
		@(negedge clk);
		compare("ack", data_t'(ack), '0); // Every earlier ack must have been a single pulse.
		wr = st_wr;
		atomic = st_atomic;
		funct = st_funct;
		tid = st_tid;
		addr = st_addr;
		wdata = st_wdata;
		req = mask;
		@(negedge clk);
		req = '0;
	endtask

	task automatic issue_and_wait(input pu_mask_t mask);
		pu_mask_t pending;
		int cycles;
		drive_request(mask);
		pending = mask;
		cycles = 0;
		while (pending != '0) begin
			for (int p = 0; p < NUM_PU; p++) begin
				if (ack[p] && !pending[p]) begin
					$display("PU %0d got an ack while it had no request open", p);
					end_with_failure();
				end else if (ack[p]) begin
					got_data[p] = ack_data[p];
					pending[p] = 1'b0;
				end
			end
			if (pending != '0 && cycles == ACK_TIMEOUT) begin
				$display("Timed out waiting for the acks of PU mask %b", pending);
				end_with_failure();
			end else if (pending != '0) begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	task automatic check_acks(input pu_mask_t mask);
		for (int p = 0; p < NUM_PU; p++) begin
			if (mask[p])
				compare($sformatf("ack_data[%0d]", p), got_data[p], exp_data[p]);
		end
	endtask

	// Atomics on one word see each other's results, so no two old words can match.
	task automatic check_distinct(input pu_mask_t mask);
		for (int i = 0; i < NUM_PU; i++) begin
			for (int j = i + 1; j < NUM_PU; j++) begin
				if (mask[i] && mask[j] && got_data[i] == got_data[j]) begin
					$display("PUs %0d and %0d both got old word %h", i, j, got_data[i]);
					end_with_failure();
				end
			end
		end
	endtask

	task automatic read_check();
		logic [31:0] t;
		logic [31:0] a;
		logic [31:0] ex;
		int n;
		n = $fscanf(fd, "%h %h %h", t, a, ex);
		if (n != 3) begin
			$display("A read check line in the data file is missing fields");
			end_with_failure();
		end else begin
			clear_staging();
			stage(0, 32'd0, 32'd0, t, a, 32'd0);
			issue_and_wait(pu_mask_t'(1));
			compare("ack_data[0] of read check", got_data[0], ex);
		end
	endtask

	task automatic dropped_request();
		logic [31:0] p;
		logic [31:0] t;
		logic [31:0] a;
		logic [31:0] wd;
		int n;
		n = $fscanf(fd, "%h %h %h %h", p, t, a, wd);
		if (n != 4) begin
			$display("A dropped request line in the data file is missing fields");
			end_with_failure();
		end else begin
			clear_staging();
			stage(int'(p[PU_ID_W-1:0]), 32'd1, 32'd0, t, a, wd);
			drive_request(pu_mask_t'(1) << p[PU_ID_W-1:0]);
			for (int c = 0; c < DROP_WINDOW; c++) begin
				@(negedge clk);
				compare("ack", data_t'(ack), '0);
			end
		end
	endtask

	initial begin
		logic [31:0] op;
		logic [31:0] mask_v;
		logic [8*128-1:0] rest;
		int n;
		bit done;
		reset = 1'b1;
		req = '0;
		wr = '0;
		atomic = '0;
		funct = '0;
		tid = '0;
		addr = '0;
		wdata = '0;
		clear_staging();
		fd = $fopen("verification/pu_topic_mem_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open verification/pu_topic_mem_testdata.txt");
			end_with_failure();
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;
		done = 1'b0;
		while (!done) begin
			n = $fscanf(fd, "%h", op);
			if (n == 1) begin
				case (op)
					32'd1, 32'd2: begin
						n = $fscanf(fd, "%h", mask_v);
						if (n != 1) begin
							$display("A request line in the data file has no PU mask");
							end_with_failure();
						end else begin
							load_fields(mask_v[NUM_PU-1:0]);
							issue_and_wait(mask_v[NUM_PU-1:0]);
							if (op == 32'd1)
								check_acks(mask_v[NUM_PU-1:0]);
							else
								check_distinct(mask_v[NUM_PU-1:0]);
						end
					end
					32'd3: read_check();
					32'd4: dropped_request();
					default: begin
						$display("Unknown operation code %h in the data file", op);
						end_with_failure();
					end
				endcase
			end else if (n == 0) begin
				n = $fgets(rest, fd); // Comment line
				done = n == 0;
			end else begin
				done = 1'b1;
			end
		end
		$fclose(fd);
		$display("all tests passed");
		$finish;
	end

endmodule

/* verification/pu_topic_mem_testdata.txt */
# 1 mask, then per set bit from PU 0 up: kind funct tid addr wdata ack_data (kind 0 rd 1 wr 2 amo)
# 2 mask: same fields, old words must differ. 3 tid addr word: read check. 4 pu tid addr wdata: no ack
# Write then read back on one word.
1 1 1 00 0 3005 12345678 0
1 1 0 00 0 3005 0 12345678
# Same word offset under other thread ids.
1 2 1 00 1 3005 aaaa0001 0
1 4 1 00 2 3005 bbbb0002 0
1 8 0 00 1 3005 0 aaaa0001
1 2 0 00 2 3005 0 bbbb0002
3 0 3005 12345678
# Every AMO function, each returning the old word.
1 1 1 00 0 3010 10 0
1 1 2 00 0 3010 5 10
3 0 3010 15
1 1 2 01 0 3010 f0f0f0f0 15
1 1 2 04 0 3010 ff00ff00 f0f0f0f0
1 1 2 08 0 3010 1 0ff00ff0
1 1 2 0c 0 3010 00ff00ff 0ff00ff1
3 0 3010 00f000f1
1 1 2 10 0 3010 fffffff0 00f000f1
1 1 2 14 0 3010 3 fffffff0
1 1 2 18 0 3010 ffffff00 3
1 1 2 1c 0 3010 ffffff00 3
1 1 2 10 0 3010 80000000 ffffff00
1 1 2 14 0 3010 ffffffff 80000000
1 1 2 18 0 3010 7fffffff ffffffff
1 1 2 1c 0 3010 80000001 7fffffff
3 0 3010 80000001
# Four atomic adds on one word in the same cycle.
1 1 1 00 3 3020 100 0
2 f 2 00 3 3020 1 0 2 00 3 3020 10 0 2 00 3 3020 100 0 2 00 3 3020 1000 0
3 3 3020 1211
# Four PUs at once on different words.
1 f 1 00 0 3030 11110000 0 1 00 1 3031 22220000 0 1 00 2 3032 33330000 0 1 00 3 3033 44440000 0
1 f 0 00 0 3030 0 11110000 1 00 1 3034 55550000 0 0 00 2 3032 0 33330000 1 00 3 3035 66660000 0
1 f 0 00 0 3030 0 11110000 0 00 1 3031 0 22220000 0 00 2 3032 0 33330000 0 00 3 3033 0 44440000
3 1 3034 55550000
3 3 3035 66660000
# Region 1 belongs elsewhere, so no ack and the word keeps its value.
4 2 0 1005 deadbeef
3 0 3005 12345678

/* pu_topic_mem.f */
design/pu_mem_pkg.sv
design/req_slot.sv
design/rr_arbiter.sv
design/amo_alu.sv
design/ram_1r1w.sv
design/pu_topic_mem.sv
verification/pu_topic_mem_tb.sv

/* Makefile */
TOOL = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = pu_topic_mem_tb
FILE_LIST = pu_topic_mem.f
BUILD_DIR = obj_dir
PASS_TEXT = all tests passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
